// File: dv/lcd_testdata.txt
# cmd_word param_word n_bytes delay b0 b1 b2 b3 b4 (words and bytes in hex)
# n_bytes counts the command byte, delay is 1 for a settling delay, unused bytes are 00
0000002A 0000013F 5 0 2A 00 00 01 3F
0000002B 000000EF 5 0 2B 00 00 00 EF
00000029 00000000 1 0 29 00 00 00 00
00000300 12345678 1 0 00 00 00 00 00
000002B1 A1B2C3D4 3 0 B1 A1 B2 00 00
000009C0 11223344 5 0 C0 11 22 33 44
000000B6 CAFEF00D 1 0 B6 00 00 00 00
00000001 00000000 1 1 01 00 00 00 00
0000033A 55000000 2 0 3A 55 00 00 00
0000002C F800001F 3 0 2C F8 00 00 00
00000011 00000000 1 1 11 00 00 00 00
00000F28 00000000 1 0 28 00 00 00 00
000004E0 DEADBEEF 5 0 E0 DE AD BE EF
00000010 00000000 1 1 10 00 00 00 00
00000FB1 01020304 5 0 B1 01 02 03 04
0000002A 00EF0140 5 0 2A 00 EF 01 40
00000029 00000000 1 0 29 00 00 00 00

// File: all.f
hw/lcd_pkg.sv
hw/lcd_apb_regs.sv
hw/lcd_cmd_table.sv
hw/lcd_bus_seq.sv
hw/lcd_delay_timer.sv
hw/lcd_ctrl_top.sv
dv/lcd_clk_gen.sv
dv/lcd_ctrl_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f all.f --top-module lcd_ctrl_tb -Mdir obj_dir -o lcd_ctrl_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/lcd_ctrl_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Everything OK" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

// File: dv/lcd_ctrl_tb.sv
`timescale 1ns/1ps

module lcd_ctrl_tb import lcd_pkg::*; ();

    logic      clk;
    logic      nrst;
    lcd_addr_t paddr;
    logic      psel;
    logic      penable;
    logic      pwrite;
    lcd_word_t pwdata;
    lcd_word_t prdata;
    logic      pready;
    lcd_byte_t lcd_data;
    logic      csx;
    logic      dcx;
    logic      wrx;

    lcd_word_t   cmd_words[$];
    lcd_word_t   param_words[$];
    logic [39:0] line_bytes[$];     // first bus byte in the top 8 bits
    int          byte_counts[$];
    int          delay_flags[$];
    logic [8:0]  exp_bytes[$];      // {dcx, data} in bus order
    int          exp_busy[$];
    int          busy_len = 0;
    bit          loaded = 1'b0;

    lcd_clk_gen lcd_clk_gen_inst (.clk(clk), .nrst(nrst));

    lcd_ctrl_top lcd_ctrl_top_inst (
        .clk(clk), .nrst(nrst),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
        .prdata(prdata), .pready(pready),
        .lcd_data(lcd_data), .csx(csx), .dcx(dcx), .wrx(wrx)
    );

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] want,
                               input logic [31:0] got);
        assert (got == want)
            else stop_with_failure($sformatf("ERR %0t %s: expected %0h, got %0h",
                                             $time, name, want, got));
    endtask

    task automatic load_testdata();
        int        fd;
        int        fields;
        string     line;
        lcd_word_t cw;
        lcd_word_t pw;
        int        nb;
        int        dl;
        lcd_byte_t b[5];
        fd = $fopen("dv/lcd_testdata.txt", "r");
        assert (fd != 0) else stop_with_failure("could not open dv/lcd_testdata.txt");
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") continue;
            fields = $sscanf(line, "%h %h %d %d %h %h %h %h %h",
                             cw, pw, nb, dl, b[0], b[1], b[2], b[3], b[4]);
            assert (fields == 9 && nb >= 1 && nb <= 5)
                else stop_with_failure({"malformed test data line: ", line});
            cmd_words.push_back(cw);
            param_words.push_back(pw);
            byte_counts.push_back(nb);
            delay_flags.push_back(dl);
            line_bytes.push_back({b[0], b[1], b[2], b[3], b[4]});
        end
        $fclose(fd);
    endtask

    // command byte goes out with dcx low, the rest with dcx high
    task automatic queue_expected(input int i);
        logic [39:0] bytes;
        bytes = line_bytes[i];
        for (int k = 0; k < byte_counts[i]; k++) begin
            exp_bytes.push_back({(k != 0), bytes[39 - 8*k -: 8]});
        end
        exp_busy.push_back(2 * byte_counts[i] + 1
                           + (delay_flags[i] != 0 ? int'(DELAY_CYCLES) : 0));
    endtask

    task automatic apb_transfer(input logic write, input lcd_addr_t addr,
                                input lcd_word_t wdata, output lcd_word_t rdata);
        @(posedge clk);
        paddr  <= addr;
        pwdata <= wdata;
        pwrite <= write;
        psel   <= 1'b1;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        while (!pready) @(posedge clk);   // command write held off while busy
        rdata = prdata;
        psel    <= 1'b0;
        penable <= 1'b0;
        repeat ($urandom_range(0, 3)) @(posedge clk);
    endtask

    task automatic wait_until_idle();
        lcd_word_t status;
        status = 32'h1;
        while (status[0]) apb_transfer(1'b0, ADDR_STATUS, '0, status);
    endtask

    // every strobed byte against the data file
    always @(posedge wrx) begin
        logic [8:0] want;
        if (nrst) begin
            assert (exp_bytes.size() > 0) else stop_with_failure("byte strobed with none expected");
            want = exp_bytes.pop_front();
            check_value("csx", 32'd0, 32'(csx));
            check_value("dcx", 32'(want[8]), 32'(dcx));
            check_value("lcd_data", 32'(want[7:0]), 32'(lcd_data));
        end
    end

    // length of each busy period, probed inside the DUT
    always @(posedge clk) begin
        if (lcd_ctrl_top_inst.busy) begin
            busy_len++;
        end else if (busy_len != 0) begin
            assert (exp_busy.size() > 0) else stop_with_failure("busy with no command written");
            check_value("busy cycles", 32'(exp_busy.pop_front()), 32'(busy_len));
            busy_len = 0;
        end
    end

    initial begin
        int limit;
        wait (loaded);
        limit = (cmd_words.size() + 2) * (int'(DELAY_CYCLES) + 20);
        repeat (limit) @(posedge clk);
        stop_with_failure($sformatf("timeout, run still going after %0d cycles", limit));
    end

    initial begin
        lcd_word_t rdata;
        void'($urandom(47130));
        paddr   <= '0;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        pwdata  <= '0;
        load_testdata();
        loaded = 1'b1;
        wait (nrst);
        @(posedge clk);
        check_value("csx", 32'd1, 32'(csx));
        check_value("wrx", 32'd1, 32'(wrx));
        check_value("pready", 32'd1, 32'(pready));
        apb_transfer(1'b0, ADDR_STATUS, '0, rdata);
        check_value("status", 32'd0, rdata);
        for (int i = 0; i < cmd_words.size(); i++) begin
            queue_expected(i);
            apb_transfer(1'b1, ADDR_PARAM, param_words[i], rdata);
            apb_transfer(1'b1, ADDR_CMD, cmd_words[i], rdata);
            if (i % 2 == 1) wait_until_idle();  // even lines run straight into the next
        end
        wait_until_idle();
        repeat (2) @(posedge clk);
        if (exp_bytes.size() == 0 && exp_busy.size() == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            stop_with_failure("bytes or busy periods still missing at the end of the run");
        end
    end

endmodule

// File: dv/lcd_clk_gen.sv
`timescale 1ns/1ps

module lcd_clk_gen (
    output logic clk,
    output logic nrst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns period
    end

    // reset held over the first two rising edges
    initial begin
        nrst <= 1'b0;
        repeat (2) @(posedge clk);
        nrst <= 1'b1;
    end

endmodule

// File: hw/lcd_ctrl_top.sv
`timescale 1ns/1ps

module lcd_ctrl_top import lcd_pkg::*; (
    input  logic      clk,
    input  logic      nrst,
    input  lcd_addr_t paddr,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  lcd_word_t pwdata,
    output lcd_word_t prdata,
    output logic      pready,
    output lcd_byte_t lcd_data,
    output logic      csx,      // active low
    output logic      dcx,      // 0 command, 1 parameter
    output logic      wrx       // active low, latched on rising edge
);

    logic       start;
    logic       busy;
    lcd_byte_t  cmd_code;
    logic [3:0] req_count;
    lcd_word_t  param_word;
    lcd_count_t param_count;
    logic       needs_delay;
    logic       timer_start;
    logic       timer_done;

    lcd_apb_regs lcd_apb_regs_inst (
        .clk(clk), .nrst(nrst),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
        .busy(busy), .prdata(prdata), .pready(pready), .start(start),
        .cmd_code(cmd_code), .req_count(req_count), .param_word(param_word)
    );

    lcd_cmd_table lcd_cmd_table_inst (
        .cmd_code(cmd_code), .req_count(req_count),
        .param_count(param_count), .needs_delay(needs_delay)
    );

    lcd_bus_seq lcd_bus_seq_inst (
        .clk(clk), .nrst(nrst), .start(start),
        .cmd_code(cmd_code), .param_word(param_word),
        .param_count(param_count), .needs_delay(needs_delay),
        .timer_done(timer_done), .timer_start(timer_start), .busy(busy),
        .lcd_data(lcd_data), .csx(csx), .dcx(dcx), .wrx(wrx)
    );

    lcd_delay_timer lcd_delay_timer_inst (
        .clk(clk), .nrst(nrst), .timer_start(timer_start), .timer_done(timer_done)
    );

endmodule

// File: hw/lcd_delay_timer.sv
`timescale 1ns/1ps

module lcd_delay_timer import lcd_pkg::*; (
    input  logic clk,
    input  logic nrst,
    input  logic timer_start,
    output logic timer_done
);

    logic       running;
    lcd_delay_t cnt;

    // done lands in the last of DELAY_CYCLES cycles after the load
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            running    <= 1'b0;
            cnt        <= '0;
            timer_done <= 1'b0;
        end else begin
            timer_done <= 1'b0;
            if (timer_start) begin
                running <= 1'b1;
                cnt     <= 24'd1;
            end else if (running) begin
                if (cnt == DELAY_CYCLES - 24'd1) begin
                    running    <= 1'b0;     // back to idle
                    timer_done <= 1'b1;
                end else begin
                    cnt <= cnt + 24'd1;
                end
            end
        end
    end

endmodule

// File: hw/lcd_bus_seq.sv
`timescale 1ns/1ps

module lcd_bus_seq import lcd_pkg::*; (
    input  logic       clk,
    input  logic       nrst,
    input  logic       start,
    input  lcd_byte_t  cmd_code,
    input  lcd_word_t  param_word,
    input  lcd_count_t param_count,
    input  logic       needs_delay,
    input  logic       timer_done,
    output logic       timer_start,
    output logic       busy,
    output lcd_byte_t  lcd_data,
    output logic       csx,
    output logic       dcx,
    output logic       wrx
);

    seq_state_t state, state_nx;
    lcd_word_t  par_q;      // parameter bytes with the msb sent first
    lcd_count_t cnt_q;      // bytes to send
    lcd_count_t sent_q;     // bytes already strobed
    logic       delay_q;

    always_comb begin
        state_nx    = state;
        timer_start = 1'b0;
        case (state)
            IDLE: begin
                if (start) state_nx = SEND_CMD;
            end
            SEND_CMD: state_nx = STROBE_CMD;
            STROBE_CMD: begin
                if (cnt_q != '0) begin
                    state_nx = SEND_PAR;
                end else if (delay_q) begin
                    state_nx    = DELAY;
                    timer_start = 1'b1;
                end else begin
                    state_nx = FINISH;
                end
            end
            SEND_PAR: state_nx = STROBE_PAR;
            STROBE_PAR: begin
                if (sent_q + 3'd1 != cnt_q) begin
                    state_nx = SEND_PAR;
                end else if (delay_q) begin
                    state_nx    = DELAY;
                    timer_start = 1'b1;
                end else begin
                    state_nx = FINISH;
                end
            end
            DELAY: begin
                if (timer_done) state_nx = FINISH;
            end
            FINISH:  state_nx = IDLE;
            default: state_nx = IDLE;
        endcase
    end

    // outputs registered off the next state so the strobes stay clean
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state    <= IDLE;
            cnt_q    <= '0;
            sent_q   <= '0;
            delay_q  <= 1'b0;
            busy     <= 1'b0;
            csx      <= 1'b1;
            dcx      <= 1'b0;
            wrx      <= 1'b1;
            lcd_data <= '0;
        end else begin
            state <= state_nx;
            busy  <= (state_nx != IDLE);
            csx   <= !(state_nx inside {SEND_CMD, STROBE_CMD, SEND_PAR, STROBE_PAR});
            dcx   <= (state_nx inside {SEND_PAR, STROBE_PAR});
            wrx   <= !(state_nx inside {SEND_CMD, SEND_PAR});  // low while data sets up

            if (state == IDLE && start) begin
                cnt_q    <= param_count;
                delay_q  <= needs_delay;
                sent_q   <= '0;
                lcd_data <= cmd_code;
            end
            if (state_nx == SEND_PAR) begin
                lcd_data <= par_q[31:24];
            end
            if (state == STROBE_PAR) sent_q <= sent_q + 3'd1;
        end
    end

    // next parameter byte moves to the top as the current one is strobed
    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            par_q <= param_word;
        end else if (state == SEND_PAR) begin
            par_q <= {par_q[23:0], 8'h00};  // next byte up
        end
    end

endmodule

// File: hw/lcd_cmd_table.sv
`timescale 1ns/1ps

module lcd_cmd_table import lcd_pkg::*; (
    input  lcd_byte_t  cmd_code,
    input  logic [3:0] req_count,
    output lcd_count_t param_count,
    output logic       needs_delay
);

    lcd_count_t clipped;    // software count, limited to what the seq can send

    assign clipped = (req_count > {1'b0, MAX_PARAMS}) ? MAX_PARAMS : req_count[2:0];

    always_comb begin
        needs_delay = 1'b0;
        case (cmd_code)
            CMD_CASET, CMD_PASET: param_count = 3'd4;   // start/end column or page
            CMD_RAMWR:            param_count = 3'd2;
            CMD_PIXFMT:           param_count = 3'd1;
            CMD_NOP, CMD_DISPOFF, CMD_DISPON: begin
                param_count = 3'd0;
            end
            CMD_SWRESET, CMD_SLPIN, CMD_SLPOUT: begin
                // driver needs time to settle after these
                param_count = 3'd0;
                needs_delay = 1'b1;
            end
            default:              param_count = clipped;
        endcase
    end

endmodule

// File: hw/lcd_apb_regs.sv
`timescale 1ns/1ps

module lcd_apb_regs import lcd_pkg::*; (
    input  logic      clk,
    input  logic      nrst,
    input  lcd_addr_t paddr,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  lcd_word_t pwdata,
    input  logic      busy,
    output lcd_word_t prdata,
    output logic      pready,
    output logic      start,
    output lcd_byte_t cmd_code,
    output logic [3:0] req_count,
    output lcd_word_t param_word
);

    logic cmd_access;   // access phase of a write to the command reg
    logic wr_done;      // write completes this cycle

    assign cmd_access = psel && penable && pwrite && (paddr == ADDR_CMD);

    // stall the command write until the sequencer is free
    assign pready = !(cmd_access && busy);

    assign wr_done = psel && penable && pwrite && pready;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            param_word <= '0;
            cmd_code   <= '0;
            req_count  <= '0;
            start      <= 1'b0;
        end else begin
            start <= 1'b0;  // one cycle pulse
            if (wr_done) begin
                case (paddr)
                    ADDR_PARAM: begin
                        param_word <= pwdata;
                    end
                    ADDR_CMD: begin
                        cmd_code  <= pwdata[7:0];
                        req_count <= pwdata[11:8];
                        start     <= 1'b1;  // kicks the sequencer next edge
                    end
                    default: begin
                        // status is read only
                    end
                endcase
            end
        end
    end

    // read mux, zero wait states
    always_comb begin
        prdata = '0;
        if (psel && !pwrite) begin
            case (paddr)
                ADDR_PARAM: begin
                    prdata = param_word;
                end
                ADDR_CMD: begin
                    prdata = {20'd0, req_count, cmd_code};
                end
                ADDR_STATUS: begin
                    prdata = {31'd0, busy};
                end
                default: begin
                    prdata = '0;
                end
            endcase
        end
    end

endmodule

// File: hw/lcd_pkg.sv
package lcd_pkg;

    // vector types with a meaning on the bus or in the regs
    typedef logic [7:0]  lcd_byte_t;
    typedef logic [31:0] lcd_word_t;
    typedef logic [3:0]  lcd_addr_t;
    typedef logic [2:0]  lcd_count_t;   // 0..4 parameter bytes
    typedef logic [23:0] lcd_delay_t;

    // apb register offsets
    localparam lcd_addr_t ADDR_PARAM  = 4'h0;
    localparam lcd_addr_t ADDR_CMD    = 4'h4;  // [7:0] code, [11:8] count
    localparam lcd_addr_t ADDR_STATUS = 4'h8;  // [0] busy

    localparam lcd_delay_t DELAY_CYCLES = 24'd480;  // settle time after reset/sleep
    localparam lcd_count_t MAX_PARAMS   = 3'd4;

    // ili9341 command codes
    localparam lcd_byte_t CMD_NOP     = 8'h00;
    localparam lcd_byte_t CMD_SWRESET = 8'h01;
    localparam lcd_byte_t CMD_SLPIN   = 8'h10;
    localparam lcd_byte_t CMD_SLPOUT  = 8'h11;
    localparam lcd_byte_t CMD_DISPOFF = 8'h28;
    localparam lcd_byte_t CMD_DISPON  = 8'h29;
    localparam lcd_byte_t CMD_CASET   = 8'h2A;
    localparam lcd_byte_t CMD_PASET   = 8'h2B;
    localparam lcd_byte_t CMD_RAMWR   = 8'h2C;
    localparam lcd_byte_t CMD_PIXFMT  = 8'h3A;

    // byte sequencer states
    typedef enum logic [2:0] {
        IDLE,
        SEND_CMD,
        STROBE_CMD,
        SEND_PAR,
        STROBE_PAR,
        DELAY,
        FINISH
    } seq_state_t;

endpackage
